// File: src/lsu_pkg.sv
package lsu_pkg;

    // bus and field widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;
    typedef logic [1:0]  size_t;

    // access size on the mask port
    localparam size_t SIZE_NONE = 2'b00;
    localparam size_t SIZE_BYTE = 2'b01;
    localparam size_t SIZE_HALF = 2'b10;
    localparam size_t SIZE_WORD = 2'b11;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    // timer window with mtime low word at base and high word at base + 4
    localparam addr_t CLINT_BASE = 32'h0200_0000;
    localparam addr_t CLINT_END  = 32'h0200_ffff;

    // data memory window
    localparam addr_t SRAM_BASE  = 32'h8000_0000;
    localparam int    SRAM_WORDS = 256;            // 1 KiB
    localparam int    SRAM_AW    = $clog2(SRAM_WORDS);

endpackage

// File: src/clint.sv
`timescale 1ns/10ps

module clint (
    input  logic           clk,
    input  logic           rst,
    input  lsu_pkg::addr_t araddr,
    input  logic           arvalid,
    output logic           arready,
    output logic           rvalid,
    output lsu_pkg::data_t rdata,
    output lsu_pkg::resp_t rresp,
    input  logic           rready
);

    import lsu_pkg::*;

    logic [63:0] mtime;

    assign arready = 1'b1;
    assign rresp   = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (rst)
            mtime <= '0;
        else
            mtime <= mtime + 64'd1;
    end

    always_ff @(posedge clk) begin
        if (rst)
            rvalid <= 1'b0;
        else if (arvalid && arready)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    // sampled at the address beat
    always_ff @(posedge clk) begin
        if (arvalid && arready)
            rdata <= araddr[2] ? mtime[63:32] : mtime[31:0];
    end

endmodule

// File: src/sram.sv
`timescale 1ns/10ps

module sram (
    input  logic           clk,
    input  logic           rst,

    input  lsu_pkg::addr_t araddr,
    input  logic           arvalid,
    output logic           arready,
    output logic           rvalid,
    input  logic           rready,
    output lsu_pkg::data_t rdata,
    output lsu_pkg::resp_t rresp,

    input  lsu_pkg::addr_t awaddr,
    input  logic           awvalid,
    output logic           awready,
    input  logic           wvalid,
    output logic           wready,
    input  lsu_pkg::data_t wdata,
    input  lsu_pkg::strb_t wstrb,

    output logic           bvalid,
    input  logic           bready,
    output lsu_pkg::resp_t bresp
);

    import lsu_pkg::*;

    data_t mem [SRAM_WORDS];

    logic  aw_got;
    logic  w_got;
    logic  aw_done;
    logic  w_done;
    logic  wr_fire;
    addr_t awaddr_q;
    data_t wdata_q;
    strb_t wstrb_q;
    addr_t wr_addr;
    data_t wr_data;
    strb_t wr_strb;
    logic [SRAM_AW-1:0] rd_idx;
    logic [SRAM_AW-1:0] wr_idx;

    function automatic logic in_window(addr_t a);
        return addr_t'(a - SRAM_BASE) < addr_t'(SRAM_WORDS * 4);
    endfunction

    assign rd_idx = araddr[SRAM_AW+1:2];
    assign wr_idx = wr_addr[SRAM_AW+1:2];

    // read channel
    assign arready = ~rvalid;

    always_ff @(posedge clk) begin
        if (rst)
            rvalid <= 1'b0;
        else if (arvalid && arready)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;  // held under back-pressure
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata <= in_window(araddr) ? mem[rd_idx] : '0;
            rresp <= in_window(araddr) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // write address and data taken in either order
    assign awready = ~aw_got & ~bvalid;
    assign wready  = ~w_got & ~bvalid;
    assign aw_done = aw_got | (awvalid & awready);
    assign w_done  = w_got | (wvalid & wready);
    assign wr_fire = aw_done & w_done & ~bvalid;

    assign wr_addr = aw_got ? awaddr_q : awaddr;
    assign wr_data = w_got ? wdata_q : wdata;
    assign wr_strb = w_got ? wstrb_q : wstrb;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            bvalid <= 1'b0;
        end else if (wr_fire) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            bvalid <= 1'b1;
        end else begin
            if (awvalid && awready)
                aw_got <= 1'b1;
            if (wvalid && wready)
                w_got <= 1'b1;
            if (bvalid && bready)
                bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready)
            awaddr_q <= awaddr;
        if (wvalid && wready) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
    end

    // byte lanes, memory untouched outside the window
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= in_window(wr_addr) ? RESP_OKAY : RESP_SLVERR;
            if (in_window(wr_addr)) begin
                for (int i = 0; i < 4; i++) begin
                    if (wr_strb[i])
                        mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

endmodule

// File: src/lsu.sv
`timescale 1ns/10ps

module lsu (
    input  logic           clk,
    input  logic           rst,
    input  logic           ready,
    input  logic           wen,
    input  logic           ren,
    input  logic           sign,
    input  lsu_pkg::size_t mask,
    input  lsu_pkg::addr_t addr,
    input  lsu_pkg::data_t wdata,
    output lsu_pkg::data_t rdata,
    output logic           valid,
    output logic           err,

    // read address shared by both targets
    output lsu_pkg::addr_t araddr,
    output logic           rready,

    // clint, read only
    output logic           arvalid_clint,
    input  logic           arready_clint,
    input  logic           rvalid_clint,
    input  lsu_pkg::data_t rdata_clint,
    input  lsu_pkg::resp_t rresp_clint,

    // sram read
    output logic           arvalid_sram,
    input  logic           arready_sram,
    input  logic           rvalid_sram,
    input  lsu_pkg::data_t rdata_sram,
    input  lsu_pkg::resp_t rresp_sram,

    // sram write and response
    output logic           awvalid_sram,
    output lsu_pkg::addr_t awaddr_sram,
    input  logic           awready_sram,
    output logic           wvalid_sram,
    output lsu_pkg::data_t wdata_sram,
    output lsu_pkg::strb_t wstrb_sram,
    input  logic           wready_sram,
    input  logic           bvalid_sram,
    input  lsu_pkg::resp_t bresp_sram,
    output logic           bready_sram
);

    import lsu_pkg::*;

    logic   arvalid;
    logic   awvalid;
    logic   wvalid;
    logic   pend;       // access in flight
    logic   valid_t;
    logic   err_t;
    logic   is_clint;
    logic   arready;
    logic   rvalid;
    resp_t  rresp;
    data_t  rdata_sel;
    strb_t  wstrb;
    data_t  wmem;
    data_t  rmem;
    data_t  rshift;
    logic [4:0] shamt;

    assign is_clint = (addr >= CLINT_BASE) && (addr <= CLINT_END);
    assign shamt    = {addr[1:0], 3'b000};  // byte offset in bits

    // lane placement for stores
    always_comb begin
        case (mask)
            SIZE_BYTE: wstrb = 4'b0001 << addr[1:0];
            SIZE_HALF: wstrb = 4'b0011 << addr[1:0];
            SIZE_WORD: wstrb = 4'b1111;
            default:   wstrb = 4'b0000;
        endcase
    end

    assign wmem   = wdata << shamt;
    assign rshift = rmem >> shamt;

    // load extension
    always_comb begin
        case (mask)
            SIZE_BYTE: rdata = {{24{rshift[7] & sign}}, rshift[7:0]};
            SIZE_HALF: rdata = {{16{rshift[15] & sign}}, rshift[15:0]};
            SIZE_WORD: rdata = rshift;
            default:   rdata = '0;
        endcase
    end

    // read steering by window
    assign araddr        = addr;
    assign arvalid_clint = arvalid & is_clint;
    assign arvalid_sram  = arvalid & ~is_clint;
    assign arready       = is_clint ? arready_clint : arready_sram;
    assign rvalid        = is_clint ? rvalid_clint  : rvalid_sram;
    assign rresp         = is_clint ? rresp_clint   : rresp_sram;
    assign rdata_sel     = is_clint ? rdata_clint   : rdata_sram;
    assign rready        = 1'b1;

    // clint has no write port, stores always go to sram which
    // answers slverr outside its own window
    assign awvalid_sram = awvalid;
    assign awaddr_sram  = addr;
    assign wvalid_sram  = wvalid;
    assign wdata_sram   = wmem;
    assign wstrb_sram   = wstrb;
    assign bready_sram  = 1'b1;

    // channel valids
    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else begin
            if (arvalid && arready)
                arvalid <= 1'b0;
            if (awvalid && awready_sram)
                awvalid <= 1'b0;
            if (wvalid && wready_sram)
                wvalid <= 1'b0;
            if (ren && ready)
                arvalid <= 1'b1;
            if (wen && ready) begin
                awvalid <= 1'b1;
                wvalid  <= 1'b1;
            end
        end
    end

    // completion, one cycle after the response beat
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_t <= 1'b0;
            err_t   <= 1'b0;
            pend    <= 1'b0;
        end else begin
            valid_t <= 1'b0;
            err_t   <= 1'b0;
            if (rvalid && rready) begin
                valid_t <= 1'b1;
                err_t   <= |rresp;
            end else if (bvalid_sram && bready_sram) begin
                valid_t <= 1'b1;
                err_t   <= |bresp_sram;
            end
            if (valid_t)
                pend <= 1'b0;
            if ((ren || wen) && ready)
                pend <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rvalid && rready)
            rmem <= rdata_sel;  // raw word, aligned later
    end

    assign valid = (pend || ren || wen) ? valid_t : ready;
    assign err   = err_t;

endmodule

// File: src/mem_subsys_top.sv
`timescale 1ns/10ps

module mem_subsys_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           ready,
    input  logic           wen,
    input  logic           ren,
    input  logic           sign,
    input  lsu_pkg::size_t mask,
    input  lsu_pkg::addr_t addr,
    input  lsu_pkg::data_t wdata,
    output lsu_pkg::data_t rdata,
    output logic           valid,
    output logic           err
);

    import lsu_pkg::*;

    addr_t araddr;
    logic  rready;

    logic  arvalid_clint;
    logic  arready_clint;
    logic  rvalid_clint;
    data_t rdata_clint;
    resp_t rresp_clint;

    logic  arvalid_sram;
    logic  arready_sram;
    logic  rvalid_sram;
    data_t rdata_sram;
    resp_t rresp_sram;
    logic  awvalid_sram;
    addr_t awaddr_sram;
    logic  awready_sram;
    logic  wvalid_sram;
    data_t wdata_sram;
    strb_t wstrb_sram;
    logic  wready_sram;
    logic  bvalid_sram;
    resp_t bresp_sram;
    logic  bready_sram;

    lsu lsu0 (
        .clk           (clk),
        .rst           (rst),
        .ready         (ready),
        .wen           (wen),
        .ren           (ren),
        .sign          (sign),
        .mask          (mask),
        .addr          (addr),
        .wdata         (wdata),
        .rdata         (rdata),
        .valid         (valid),
        .err           (err),
        .araddr        (araddr),
        .rready        (rready),
        .arvalid_clint (arvalid_clint),
        .arready_clint (arready_clint),
        .rvalid_clint  (rvalid_clint),
        .rdata_clint   (rdata_clint),
        .rresp_clint   (rresp_clint),
        .arvalid_sram  (arvalid_sram),
        .arready_sram  (arready_sram),
        .rvalid_sram   (rvalid_sram),
        .rdata_sram    (rdata_sram),
        .rresp_sram    (rresp_sram),
        .awvalid_sram  (awvalid_sram),
        .awaddr_sram   (awaddr_sram),
        .awready_sram  (awready_sram),
        .wvalid_sram   (wvalid_sram),
        .wdata_sram    (wdata_sram),
        .wstrb_sram    (wstrb_sram),
        .wready_sram   (wready_sram),
        .bvalid_sram   (bvalid_sram),
        .bresp_sram    (bresp_sram),
        .bready_sram   (bready_sram)
    );

    clint clint0 (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arvalid (arvalid_clint),
        .arready (arready_clint),
        .rvalid  (rvalid_clint),
        .rdata   (rdata_clint),
        .rresp   (rresp_clint),
        .rready  (rready)
    );

    sram sram0 (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arvalid (arvalid_sram),
        .arready (arready_sram),
        .rvalid  (rvalid_sram),
        .rready  (rready),
        .rdata   (rdata_sram),
        .rresp   (rresp_sram),
        .awaddr  (awaddr_sram),
        .awvalid (awvalid_sram),
        .awready (awready_sram),
        .wvalid  (wvalid_sram),
        .wready  (wready_sram),
        .wdata   (wdata_sram),
        .wstrb   (wstrb_sram),
        .bvalid  (bvalid_sram),
        .bready  (bready_sram),
        .bresp   (bresp_sram)
    );

endmodule

// File: testbench/tb_mem_subsys.sv
`timescale 1ns/10ps

module tb_mem_subsys;

    import lsu_pkg::*;

    localparam int TOTAL_OPS = 1024;   // a little above the sum of all tests

    logic  clk;
    logic  rst;
    logic  ready;
    logic  wen;
    logic  ren;
    logic  sign;
    size_t mask;
    addr_t addr;
    data_t wdata;
    data_t rdata;
    logic  valid;
    logic  err;

    logic [7:0]  model [SRAM_WORDS * 4];  // byte image of the sram window
    logic [31:0] rng;
    int          cycle_cnt;
    int          done_cycle;
    int          n_checks;
    int          n_errors;
    int          chk0;
    int          err0;

    mem_subsys_top dut0 (
        .clk   (clk),
        .rst   (rst),
        .ready (ready),
        .wen   (wen),
        .ren   (ren),
        .sign  (sign),
        .mask  (mask),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .valid (valid),
        .err   (err)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst)
            cycle_cnt <= 0;
        else
            cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        repeat (TOTAL_OPS * 40 + 8) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", TOTAL_OPS * 40 + 8);
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // expected load value from the model bytes and the size/sign rules
    function automatic data_t expect_load(addr_t a, size_t m, logic s);
        int off;
        off = int'(a - SRAM_BASE);
        case (m)
            SIZE_BYTE: return {{24{s & model[off][7]}}, model[off]};
            SIZE_HALF: return {{16{s & model[off+1][7]}}, model[off+1], model[off]};
            SIZE_WORD: return {model[off+3], model[off+2], model[off+1], model[off]};
            default:   return '0;
        endcase
    endfunction

    task automatic model_store(addr_t a, size_t m, data_t d);
        int off;
        int n;
        off = int'(a - SRAM_BASE);
        n = (m == SIZE_BYTE) ? 1 : (m == SIZE_HALF) ? 2 : 4;
        for (int i = 0; i < n; i++)
            model[off+i] = d[8*i +: 8];
    endtask

    task automatic compare_value(string name, data_t got, data_t exp);
        n_checks++;
        assert (got === exp) else begin
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
            n_errors++;
        end
    endtask

    // idle cycles where valid has to follow ready
    task automatic idle_check(int n);
        logic [31:0] r;
        repeat (n) begin
            r = next_rand();
            ready = r[0];
            @(negedge clk);
            compare_value("valid", {31'b0, valid}, {31'b0, ready});
            @(posedge clk);
            #1;
        end
    endtask

    task automatic do_access(input logic is_wr, input addr_t a, input size_t m,
                             input logic s, input data_t wd,
                             output data_t rd, output logic e);
        int lat;
        lat = 0;
        addr = a;
        mask = m;
        sign = s;
        wdata = wd;
        ren = ~is_wr;
        wen = is_wr;
        ready = 1'b1;
        @(posedge clk);
        #1;
        ren = 1'b0;
        wen = 1'b0;
        ready = 1'b0;   // so a second pulse would show
        do begin
            @(negedge clk);
            lat++;
            assert (valid === 1'b1 || err === 1'b0) else begin
                $display("%0t err raised without valid", $time);
                n_errors++;
            end
        end while (valid !== 1'b1);
        rd = rdata;
        e = err;
        done_cycle = cycle_cnt;
        n_checks++;
        assert (lat >= 3) else begin
            $display("%0t completion came %0d cycles after the request, too early", $time, lat);
            n_errors++;
        end
        @(negedge clk);
        n_checks++;
        assert (valid === 1'b0 && err === 1'b0) else begin
            $display("%0t valid or err stayed high for more than one cycle", $time);
            n_errors++;
        end
        @(posedge clk);
        #1;
        idle_check(int'(next_rand() % 3));
    endtask

    task automatic load_check(addr_t a, size_t m, logic s, logic exp_err);
        data_t rd;
        logic  e;
        do_access(1'b0, a, m, s, '0, rd, e);
        if (!exp_err)
            compare_value("rdata", rd, expect_load(a, m, s));
        compare_value("err", {31'b0, e}, {31'b0, exp_err});
    endtask

    task automatic store_op(addr_t a, size_t m, data_t wd, logic exp_err);
        data_t rd;
        logic  e;
        do_access(1'b1, a, m, 1'b0, wd, rd, e);
        compare_value("err", {31'b0, e}, {31'b0, exp_err});
        if (!exp_err)
            model_store(a, m, wd);
    endtask

    task automatic verify_all_words();
        for (int i = 0; i < SRAM_WORDS; i++)
            load_check(SRAM_BASE + addr_t'(i * 4), SIZE_WORD, 1'b0, 1'b0);
    endtask

    task automatic end_test(string name);
        $display("%s: %0d checks, %0d errors", name, n_checks - chk0, n_errors - err0);
        chk0 = n_checks;
        err0 = n_errors;
    endtask

    initial begin
        logic [31:0] r;
        addr_t       off;
        size_t       m;
        int          lane;
        data_t       rd;
        data_t       prev_lo;
        data_t       delta;
        int          prev_cyc;
        logic        e;

        rst = 1'b1;
        ready = 1'b0;
        wen = 1'b0;
        ren = 1'b0;
        sign = 1'b0;
        mask = SIZE_NONE;
        addr = '0;
        wdata = '0;
        rng = 32'h4cfe8d38;
        done_cycle = 0;
        n_checks = 0;
        n_errors = 0;
        chk0 = 0;
        err0 = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        compare_value("err", {31'b0, err}, 32'd0);
        compare_value("valid", {31'b0, valid}, 32'd0);
        @(posedge clk);
        #1;

        // every word written once so later reads are defined
        for (int i = 0; i < SRAM_WORDS; i++)
            store_op(SRAM_BASE + addr_t'(i * 4), SIZE_WORD, next_rand(), 1'b0);
        verify_all_words();
        end_test("word round trip");

        for (int i = 0; i < 64; i++) begin
            r = next_rand();
            m = (i % 2 == 1) ? SIZE_HALF : SIZE_BYTE;
            lane = (m == SIZE_HALF) ? ((i / 2) % 2) * 2 : (i / 2) % 4;
            off = (r & 32'h3fc) + addr_t'(lane);
            store_op(SRAM_BASE + off, m, next_rand(), 1'b0);
            load_check(SRAM_BASE + (off & 32'h3fc), SIZE_WORD, 1'b0, 1'b0);
        end
        end_test("sub-word stores");

        for (int i = 0; i < 64; i++) begin
            r = next_rand();
            m = (i % 2 == 1) ? SIZE_HALF : SIZE_BYTE;
            lane = (m == SIZE_HALF) ? ((i / 2) % 2) * 2 : (i / 2) % 4;
            off = (r & 32'h3fc) + addr_t'(lane);
            load_check(SRAM_BASE + off, m, ((i / 8) % 2) == 1, 1'b0);
        end
        end_test("load extension");

        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            if (r[31])
                store_op(SRAM_BASE + (r & 32'h3fc), SIZE_WORD, next_rand(), 1'b0);
            else
                load_check(SRAM_BASE + (r & 32'h3fc), SIZE_WORD, 1'b0, 1'b0);
            idle_check(4);
        end
        end_test("completion handshake");

        do_access(1'b0, CLINT_BASE, SIZE_WORD, 1'b0, '0, prev_lo, e);
        compare_value("err", {31'b0, e}, 32'd0);
        prev_cyc = done_cycle;
        for (int i = 0; i < 16; i++) begin
            do_access(1'b0, CLINT_BASE, SIZE_WORD, 1'b0, '0, rd, e);
            compare_value("err", {31'b0, e}, 32'd0);
            delta = rd - prev_lo;
            n_checks++;
            assert (delta > 0 && delta <= data_t'(done_cycle - prev_cyc)) else begin
                $display("%0t timer low word moved by %0d over %0d cycles",
                         $time, delta, done_cycle - prev_cyc);
                n_errors++;
            end
            prev_lo = rd;
            prev_cyc = done_cycle;
        end
        do_access(1'b0, CLINT_BASE + 32'd4, SIZE_WORD, 1'b0, '0, rd, e);
        compare_value("rdata", rd, 32'd0);
        compare_value("err", {31'b0, e}, 32'd0);
        end_test("timer reads");

        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            if (i % 2 == 0)
                off = SRAM_BASE + 32'h400 + (r & 32'hffc);  // just above the sram
            else
                off = 32'h4000_0000 | (r & 32'h0fff_fffc);
            if (i % 4 < 2)
                load_check(off, SIZE_WORD, 1'b0, 1'b1);
            else
                store_op(off, SIZE_WORD, next_rand(), 1'b1);
        end
        verify_all_words();
        end_test("error response");

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: flist.f
src/lsu_pkg.sv
src/clint.sv
src/sram.sv
src/lsu.sv
src/mem_subsys_top.sv
testbench/tb_mem_subsys.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

obj_dir/Vtb_mem_subsys: flist.f src/*.sv testbench/*.sv
	verilator --binary --timing --assert -f flist.f --top-module tb_mem_subsys -Mdir obj_dir

test: obj_dir/Vtb_mem_subsys
	./obj_dir/Vtb_mem_subsys | tee sim.log
	@if grep -q "ALL CHECKS PASSED" sim.log; then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
